//--- design/ls_defs.svh
`ifndef LS_DEFS_SVH
`define LS_DEFS_SVH

//////////////////////////////////////////////////
// Datapath widths
//////////////////////////////////////////////////

`define XLEN 32
`define ROB_TAG_LEN 5

//////////////////////////////////////////////////
// Queue and memory sizing
//////////////////////////////////////////////////

// Queue depth must stay a power of two so the pointers wrap on their own.
`define LSQ_DEPTH 4

// Addresses wrap modulo this many words.
`define DMEM_WORDS 256
`define DMEM_LATENCY 2

`endif

//--- design/ls_pkg.sv
`default_nettype none

`include "ls_defs.svh"

package ls_pkg;

    typedef enum logic [1:0] {
        BUS_NONE  = 2'h0,
        BUS_LOAD  = 2'h1,
        BUS_STORE = 2'h2
    } bus_command_e;

    // Access size, taken from the low two bits of func3.
    typedef enum logic [1:0] {
        BYTE = 2'h0,
        HALF = 2'h1,
        WORD = 2'h2
    } mem_size_e;

    typedef enum logic [1:0] {
        LS_LOAD  = 2'h0,
        LS_LOADU = 2'h1,
        LS_STORE = 2'h2
    } ls_func_e;

    typedef struct packed {
        logic [`XLEN-1:0]        value_src1;
        logic [`XLEN-1:0]        value_src2;
        logic [`XLEN-1:0]        imm;
        logic [2:0]              func3;
        ls_func_e                func;
        logic [`ROB_TAG_LEN-1:0] insn_tag;
    } ls_insn_t;

    typedef struct packed {
        ls_insn_t     insn;
        bus_command_e mem_command;
    } ls_unit_pack_t;

    typedef struct packed {
        logic [`XLEN-1:0]        wb_data;
        logic [`ROB_TAG_LEN-1:0] inst_tag;
    } ls_result_t;

    // One memory word, addressed either by byte lane or by halfword lane.
    typedef union packed {
        logic [`XLEN/8-1:0][7:0]   byte_lane;
        logic [`XLEN/16-1:0][15:0] half_lane;
    } mem_word_u;

endpackage

`default_nettype wire

//--- design/ls_queue.sv
`timescale 1ns/1ps
`default_nettype none

`include "ls_defs.svh"

module ls_queue (
    input  logic                  clk,
    input  logic                  arst_n,
    input  ls_pkg::ls_unit_pack_t insn_in,
    input  logic                  insn_valid,
    output logic                  insn_ready,
    output ls_pkg::ls_unit_pack_t head,
    output logic                  head_valid,
    input  logic                  done
);

    import ls_pkg::*;

    localparam int PTR_W = $clog2(`LSQ_DEPTH);
    localparam logic [PTR_W:0] FULL_COUNT = (PTR_W + 1)'(`LSQ_DEPTH);

    ls_unit_pack_t    entries [`LSQ_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;
    logic             push;
    logic             pop;

    if ((`LSQ_DEPTH & (`LSQ_DEPTH - 1)) != 0) begin : g_depth_check
        $error("LSQ_DEPTH must be a power of two");
    end

    assign insn_ready = (count != FULL_COUNT);
    assign head_valid = (count != '0);
    assign head       = entries[rd_ptr];

    assign push = insn_valid && insn_ready;
    assign pop  = done && head_valid;

    //////////////////////////////////////////////////
    // Pointers and occupancy
    //////////////////////////////////////////////////

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Each push writes the slot at the write pointer.
    always_ff @(posedge clk) begin
        if (push) begin
            entries[wr_ptr] <= insn_in;
        end
    end

    //////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////

    // The unit may only complete the instruction the queue is presenting.
    assert property (@(posedge clk) disable iff (!arst_n)
        done |-> head_valid)
    else $error("done raised with no valid head entry");

    assert property (@(posedge clk) disable iff (!arst_n)
        count <= FULL_COUNT)
    else $error("queue occupancy %0d exceeds depth", count);

endmodule

`default_nettype wire

//--- design/ls_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "ls_defs.svh"

module ls_unit (
    input  ls_pkg::ls_unit_pack_t insn_in,
    input  logic                  en,
    input  logic                  mem_hit,
    input  logic [`XLEN-1:0]      load_data,
    output ls_pkg::bus_command_e  mem_command,
    output logic [`XLEN-1:0]      mem_addr,
    output logic [2:0]            func3,
    output logic [`XLEN-1:0]      proc2dmem_data,
    output ls_pkg::ls_result_t    result,
    output logic                  done
);

    import ls_pkg::*;

    logic [`XLEN-1:0] eff_addr;
    mem_word_u        load_word;
    mem_size_e        size;

    // Picks the addressed lane out of the returned word and widens it.
    function automatic logic [`XLEN-1:0] extract_load(
        input mem_word_u word,
        input logic [1:0] lane,
        input mem_size_e  sz,
        input logic       sign_ext
    );
        logic [7:0]  b;
        logic [15:0] h;
        b = word.byte_lane[lane];
        h = word.half_lane[lane[1]];
        case (sz)
            BYTE:    return {{(`XLEN-8){sign_ext & b[7]}}, b};
            HALF:    return {{(`XLEN-16){sign_ext & h[15]}}, h};
            default: return word;
        endcase
    endfunction

    assign eff_addr  = insn_in.insn.value_src1 + insn_in.insn.imm;
    assign load_word = load_data;
    assign size      = mem_size_e'(insn_in.insn.func3[1:0]);

    always_comb begin
        mem_command    = BUS_NONE;
        mem_addr       = '0;
        func3          = 3'b0;
        proc2dmem_data = '0;
        result         = '0;
        done           = 1'b0;

        if (en) begin
            mem_addr    = eff_addr;
            func3       = insn_in.insn.func3;
            mem_command = insn_in.mem_command;

            if (insn_in.mem_command == BUS_STORE) begin
                // Lane placement is left to the memory.
                proc2dmem_data = insn_in.insn.value_src2;
            end else if (insn_in.mem_command == BUS_LOAD && mem_hit) begin
                if (insn_in.insn.func == LS_LOAD) begin
                    result.wb_data = extract_load(load_word, eff_addr[1:0], size, 1'b1);
                end else if (insn_in.insn.func == LS_LOADU) begin
                    result.wb_data = extract_load(load_word, eff_addr[1:0], size, 1'b0);
                end else begin
                    result.wb_data = '0;
                end
            end

            result.inst_tag = insn_in.insn.insn_tag;
            done            = mem_hit;
        end
    end

    // Anything the queue presents as valid must be a real bus request.
    always_comb begin
        if (en) begin
            assert final (insn_in.mem_command != BUS_NONE)
            else $error("valid head carries BUS_NONE command");
        end
    end

endmodule

`default_nettype wire

//--- design/data_mem.sv
`timescale 1ns/1ps
`default_nettype none

`include "ls_defs.svh"

module data_mem (
    input  logic                 clk,
    input  logic                 arst_n,
    input  ls_pkg::bus_command_e mem_command,
    input  logic [`XLEN-1:0]     mem_addr,
    input  logic [2:0]           func3,
    input  logic [`XLEN-1:0]     proc2dmem_data,
    output logic                 mem_hit,
    output logic [`XLEN-1:0]     load_data
);

    import ls_pkg::*;

    localparam int IDX_W = $clog2(`DMEM_WORDS);
    localparam int CNT_W = $clog2(`DMEM_LATENCY + 1);

    mem_word_u        mem [`DMEM_WORDS];
    logic             busy;
    logic [CNT_W-1:0] wait_cnt;
    logic             accept;

    bus_command_e     req_cmd;
    logic [`XLEN-1:0] req_addr;
    logic [`XLEN-1:0] req_data;
    mem_size_e        req_size;
    logic [IDX_W-1:0] req_idx;
    mem_word_u        merged;

    if (`DMEM_LATENCY < 1) begin : g_latency_check
        $error("DMEM_LATENCY must be at least 1");
    end

    assign accept  = !busy && (mem_command != BUS_NONE);
    assign req_idx = req_addr[IDX_W+1:2];

    //////////////////////////////////////////////////
    // Request tracking
    //////////////////////////////////////////////////

    // The hit is raised the cycle after the counter runs down to one.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            busy     <= 1'b0;
            wait_cnt <= '0;
            mem_hit  <= 1'b0;
        end else begin
            mem_hit <= 1'b0;
            if (accept) begin
                busy     <= 1'b1;
                wait_cnt <= CNT_W'(`DMEM_LATENCY);
            end else if (mem_hit) begin
                busy <= 1'b0;
            end else if (busy && wait_cnt != '0) begin
                wait_cnt <= wait_cnt - 1'b1;
                if (wait_cnt == CNT_W'(1)) begin
                    mem_hit <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            req_cmd  <= mem_command;
            req_addr <= mem_addr;
            req_data <= proc2dmem_data;
            req_size <= mem_size_e'(func3[1:0]);
        end
    end

    //////////////////////////////////////////////////
    // Storage
    //////////////////////////////////////////////////

    // Store data arrives in the low lanes and is moved to the addressed lane here.
    always_comb begin
        merged = mem[req_idx];
        case (req_size)
            BYTE:    merged.byte_lane[req_addr[1:0]] = req_data[7:0];
            HALF:    merged.half_lane[req_addr[1]] = req_data[15:0];
            default: merged = req_data;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < `DMEM_WORDS; i++) begin
                mem[i] <= '0;
            end
        end else if (mem_hit && req_cmd == BUS_STORE) begin
            mem[req_idx] <= merged;
        end
    end

    assign load_data = (mem_hit && req_cmd == BUS_LOAD) ? mem[req_idx] : '0;

    // The requester has to hold its request until the hit.
    assert property (@(posedge clk) disable iff (!arst_n)
        busy |-> (mem_command == req_cmd && mem_addr == req_addr))
    else $error("request changed while memory busy");

endmodule

`default_nettype wire

//--- design/ls_subsystem.sv
`timescale 1ns/1ps
`default_nettype none

`include "ls_defs.svh"

module ls_subsystem (
    input  logic                  clk,
    input  logic                  arst_n,
    input  ls_pkg::ls_unit_pack_t insn_in,
    input  logic                  insn_valid,
    output logic                  insn_ready,
    output ls_pkg::ls_result_t    result,
    output logic                  done
);

    import ls_pkg::*;

    ls_unit_pack_t    head;
    logic             head_valid;
    bus_command_e     mem_command;
    logic [`XLEN-1:0] mem_addr;
    logic [2:0]       func3;
    logic [`XLEN-1:0] proc2dmem_data;
    logic             mem_hit;
    logic [`XLEN-1:0] load_data;

    ls_queue queue_i (
        .clk        (clk),
        .arst_n     (arst_n),
        .insn_in    (insn_in),
        .insn_valid (insn_valid),
        .insn_ready (insn_ready),
        .head       (head),
        .head_valid (head_valid),
        .done       (done)
    );

    // The unit works on the queue head for as long as the head is valid.
    ls_unit unit_i (
        .insn_in        (head),
        .en             (head_valid),
        .mem_hit        (mem_hit),
        .load_data      (load_data),
        .mem_command    (mem_command),
        .mem_addr       (mem_addr),
        .func3          (func3),
        .proc2dmem_data (proc2dmem_data),
        .result         (result),
        .done           (done)
    );

    data_mem mem_i (
        .clk            (clk),
        .arst_n         (arst_n),
        .mem_command    (mem_command),
        .mem_addr       (mem_addr),
        .func3          (func3),
        .proc2dmem_data (proc2dmem_data),
        .mem_hit        (mem_hit),
        .load_data      (load_data)
    );

endmodule

`default_nettype wire

//--- verification/ls_subsystem_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "ls_defs.svh"

module ls_subsystem_tb;

    import ls_pkg::*;

    localparam int TIMEOUT = 200;
    localparam int NUM_TESTS = 6;
    localparam int BURST_TEST = 5;

    typedef struct packed {
        logic [2:0]              test;
        ls_func_e                func;
        mem_size_e               size;
        logic [7:0]              off;
        logic [`XLEN-1:0]        mask;
        logic [`ROB_TAG_LEN-1:0] tag;
    } op_t;

    logic          clk = 1'b0;
    logic          arst_n = 1'b0;
    ls_unit_pack_t insn_in = '0;
    logic          insn_valid = 1'b0;
    logic          insn_ready;
    ls_result_t    result;
    logic          done;

    op_t              ops[$];
    ls_result_t       got[$];
    ls_result_t       expected[$];
    logic             is_load[$];
    logic [7:0]       model [`DMEM_WORDS*4];
    logic [`XLEN-1:0] region;
    int               errors = 0;
    int               checks = 0;
    int               failed_tests = 0;
    int               tests_run = 0;
    bit               timed_out = 1'b0;
    string            names [NUM_TESTS] = '{"idle and unwritten load", "word store and load",
        "lane merge", "sign and zero extension", "base plus immediate", "back-to-back burst"};

    ls_subsystem dut_i (
        .clk        (clk),
        .arst_n     (arst_n),
        .insn_in    (insn_in),
        .insn_valid (insn_valid),
        .insn_ready (insn_ready),
        .result     (result),
        .done       (done)
    );

    always #4 clk = ~clk;

    // Every done pulse is captured at the falling edge, where result has settled.
    always @(negedge clk) begin
        if (arst_n && done) begin
            got.push_back(result);
        end
    end

    //////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////

    task automatic check(input string name, input logic [`XLEN-1:0] actual,
                         input logic [`XLEN-1:0] exp);
        checks++;
        if (actual !== exp) begin
            errors++;
            $display("mismatch %s: got 0x%08h, expected 0x%08h", name, actual, exp);
        end
    endtask

    task automatic add_op(input int test, input ls_func_e func, input mem_size_e size,
                          input int off, input logic [`XLEN-1:0] mask, input int tag);
        ops.push_back('{test[2:0], func, size, off[7:0], mask, tag[`ROB_TAG_LEN-1:0]});
    endtask

    // Reference memory is little endian; the load reads up from the byte address.
    function automatic logic [`XLEN-1:0] load_from_model(input int a, input mem_size_e size,
                                                         input bit sgn);
        logic [`XLEN-1:0] w;
        w = {model[a+3], model[a+2], model[a+1], model[a]};
        case (size)
            BYTE:    return {{(`XLEN-8){sgn & w[7]}}, w[7:0]};
            HALF:    return {{(`XLEN-16){sgn & w[15]}}, w[15:0]};
            default: return w;
        endcase
    endfunction

    task automatic store_to_model(input int a, input mem_size_e size, input logic [`XLEN-1:0] d);
        int n;
        n = (size == BYTE) ? 1 : (size == HALF) ? 2 : 4;
        for (int k = 0; k < n; k++) begin
            model[a+k] = d[8*k +: 8];
        end
    endtask

    // Drives one entry and returns on the edge that accepts it.
    task automatic push_op(input ls_unit_pack_t p);
        int n;
        n = 0;
        insn_in    <= p;
        insn_valid <= 1'b1;
        do begin
            @(negedge clk);
            n++;
        end while (!insn_ready && n < TIMEOUT);
        if (!insn_ready) begin
            timed_out = 1'b1;
            $display("Timed out waiting for the queue to accept an instruction");
        end
        @(posedge clk);
    endtask

    task automatic wait_results(input int n);
        int cyc;
        cyc = 0;
        while (got.size() < n && cyc < TIMEOUT) begin
            @(posedge clk);
            cyc++;
        end
        if (got.size() < n) begin
            timed_out = 1'b1;
            $display("Timed out waiting for done, saw %0d of %0d results", got.size(), n);
        end
    endtask

    // The base is chosen so that base plus immediate lands on the table address.
    task automatic apply(input op_t op, input int idx);
        ls_unit_pack_t    p;
        int               a;
        logic [`XLEN-1:0] data;
        a    = region + op.off;
        data = $urandom | op.mask;
        p.insn.imm          = $urandom;
        p.insn.imm[`XLEN-1] = idx[0];
        p.insn.value_src1   = `XLEN'(a) - p.insn.imm;
        p.insn.value_src2   = data;
        p.insn.func3        = {op.func == LS_LOADU, op.size};
        p.insn.func         = op.func;
        p.insn.insn_tag     = op.tag;
        p.mem_command       = (op.func == LS_STORE) ? BUS_STORE : BUS_LOAD;
        if (op.func == LS_STORE) begin
            store_to_model(a, op.size, data);
            expected.push_back('{wb_data: '0, inst_tag: op.tag});
        end else begin
            expected.push_back('{wb_data: load_from_model(a, op.size, op.func == LS_LOAD),
                                 inst_tag: op.tag});
        end
        is_load.push_back(op.func != LS_STORE);
        push_op(p);
    endtask

    //////////////////////////////////////////////////
    // Stimulus table and run
    //////////////////////////////////////////////////

    initial begin
        int         err0;
        int         n;
        ls_result_t r;
        ls_result_t e;
        logic       ld;

        void'($urandom(32'h5546));
        foreach (model[k]) begin
            model[k] = 8'h00;
        end
        region = ($urandom % (`DMEM_WORDS - 9)) * 4;

        add_op(0, LS_LOAD, WORD, 28, 0, 1);
        add_op(1, LS_STORE, WORD, 0, 0, 2);
        add_op(1, LS_LOAD, WORD, 0, 0, 3);
        add_op(2, LS_STORE, WORD, 4, 0, 4);
        add_op(2, LS_STORE, BYTE, 4, 0, 5);
        add_op(2, LS_STORE, BYTE, 5, 0, 6);
        add_op(2, LS_LOAD, WORD, 4, 0, 7);
        add_op(2, LS_STORE, BYTE, 6, 0, 8);
        add_op(2, LS_STORE, BYTE, 7, 0, 9);
        add_op(2, LS_LOAD, WORD, 4, 0, 10);
        add_op(2, LS_STORE, HALF, 6, 0, 11);
        add_op(2, LS_LOAD, WORD, 4, 0, 12);
        add_op(2, LS_STORE, HALF, 4, 0, 13);
        add_op(2, LS_LOAD, WORD, 4, 0, 14);
        add_op(3, LS_STORE, WORD, 8, 32'h8080_8080, 15);
        add_op(3, LS_LOAD, BYTE, 9, 0, 16);
        add_op(3, LS_LOADU, BYTE, 9, 0, 17);
        add_op(3, LS_LOAD, HALF, 10, 0, 18);
        add_op(3, LS_LOADU, HALF, 10, 0, 19);
        add_op(3, LS_LOAD, BYTE, 8, 0, 20);
        add_op(3, LS_LOADU, HALF, 8, 0, 21);
        add_op(4, LS_STORE, WORD, 12, 0, 22);
        add_op(4, LS_LOAD, WORD, 12, 0, 23);
        add_op(4, LS_LOAD, HALF, 14, 0, 24);
        add_op(5, LS_STORE, WORD, 16, 0, 25);
        add_op(5, LS_STORE, HALF, 18, 32'h0000_8000, 26);
        add_op(5, LS_LOAD, WORD, 16, 0, 27);
        add_op(5, LS_LOAD, HALF, 18, 0, 28);

        repeat (8) @(posedge clk);
        arst_n <= 1'b1;

        for (int t = 0; t < NUM_TESTS && !timed_out; t++) begin
            err0 = errors;
            n    = 0;
            tests_run++;
            if (t == 0) begin
                repeat (20) @(posedge clk);
                check("done count", got.size(), 0);
            end
            for (int i = 0; i < ops.size(); i++) begin
                if (ops[i].test == t && !timed_out) begin
                    if (t != BURST_TEST || n == 0) begin
                        @(posedge clk);
                    end
                    apply(ops[i], i);
                    n++;
                    if (t != BURST_TEST) begin
                        insn_valid <= 1'b0;
                        wait_results(n);
                    end
                end
            end
            if (t == BURST_TEST) begin
                insn_valid <= 1'b0;
                @(negedge clk);
                check("insn_ready", insn_ready, 1'b0);
                wait_results(n);
            end
            // Give a stray extra pulse time to show up.
            repeat (`DMEM_LATENCY + 3) @(posedge clk);
            check("done count", got.size(), n);
            while (got.size() > 0 && expected.size() > 0) begin
                r  = got.pop_front();
                e  = expected.pop_front();
                ld = is_load.pop_front();
                if (ld) begin
                    check("wb_data", r.wb_data, e.wb_data);
                end
                check("inst_tag", r.inst_tag, e.inst_tag);
            end
            got.delete();
            expected.delete();
            is_load.delete();
            if (errors != err0 || timed_out) begin
                failed_tests++;
            end
            $display("test %0d %s: %s", t, names[t],
                     (errors == err0 && !timed_out) ? "ok" : "FAILED");
        end

        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, failed_tests, checks, errors);
        if (errors == 0 && !timed_out) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+design
design/ls_pkg.sv
design/ls_queue.sv
design/ls_unit.sv
design/data_mem.sv
design/ls_subsystem.sv
verification/ls_subsystem_tb.sv
